// File: include/heap_macros.svh
// Array heap size macros
// Address, index and data widths, and the array count and length that follow

`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

//----------------------------------------------------------------------
// Widths
//----------------------------------------------------------------------
`define HEAP_ADDRESS_BITS 3                         // Bits in an array number
`define HEAP_INDEX_BITS   3                         // Bits in an element index
`define HEAP_DATA_BITS    16                        // Width of one element

//----------------------------------------------------------------------
// Derived sizes
//----------------------------------------------------------------------
`define HEAP_ARRAYS (1 << `HEAP_ADDRESS_BITS)       // Arrays in the heap
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)         // Elements per array

`endif

// File: design/heapStoragePkg.sv
// Array heap storage types
// Widths of array numbers, element indices, element values and array sizes

`default_nettype none

`include "heap_macros.svh"

package heapStoragePkg;

  //----------------------------------------------------------------------
  // Storage widths
  //----------------------------------------------------------------------
  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayNum;      // Array number

  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex;    // Position in an array

  typedef logic [`HEAP_DATA_BITS-1:0] elementData;      // Element value

  // One bit over an index so a full array still fits
  typedef logic [`HEAP_INDEX_BITS:0] arraySize;

endpackage

`default_nettype wire

// File: design/heapOpsPkg.sv
// Array heap operation types
// Action and error codes, and the request and result records of the heap

`default_nettype none

package heapOpsPkg;

  import heapStoragePkg::*;

  //----------------------------------------------------------------------
  // Codes
  //----------------------------------------------------------------------
  typedef enum logic [7:0] {
    Write    = 8'd2,                                // Store an element
    Read     = 8'd3,                                // Fetch an element
    Size     = 8'd4,                                // Current size
    Less     = 8'd8,                                // Count below data
    Greater  = 8'd9,                                // Count above data
    Push     = 8'd14,                               // Append at the end
    Pop      = 8'd15,                               // Remove the last
    Alloc    = 8'd18,                               // New or reused array
    Free     = 8'd19,                               // Return for reuse
    Add      = 8'd20,                               // Element plus data
    Subtract = 8'd22,                               // Element minus data
    Or       = 8'd28,
    Xor      = 8'd29,
    And      = 8'd30
  } heapAction;

  typedef enum logic [3:0] {
    none         = 4'd0,
    notAllocated = 4'd1,                            // Never handed out
    freed        = 4'd2,                            // Handed out then freed
    outOfBounds  = 4'd3,                            // Index at or past size
    full         = 4'd4,                            // Push at length
    empty        = 4'd5,                            // Pop at size zero
    outOfMemory  = 4'd6                             // Every array in use
  } heapError;

  //----------------------------------------------------------------------
  // Records
  //----------------------------------------------------------------------
  typedef struct packed {
    heapAction   action;
    arrayNum     array;
    elementIndex index;
    elementData  data;                              // Operand or value to store
  } heapRequest;

  typedef struct packed {
    elementData data;                               // Value returned
    heapError   error;
  } heapResult;

endpackage

`default_nettype wire

// File: design/heapAllocator.sv
// Array allocator
// Tracks which arrays are in use, the high-water count of arrays ever handed
// out, and a last-in-first-out stack of freed arrays for reuse

`default_nettype none

`include "heap_macros.svh"

module heapAllocator (
  input  wire                    clock,
  input  wire                    reset,
  input  heapStoragePkg::arrayNum  queryArray,      // Array of the current request
  input  wire                    allocate,
  input  wire                    releaseArray,
  output logic                   arrayValid,        // Below high water
  output logic                   arrayFreed,
  output heapStoragePkg::arrayNum  nextArray,       // What Alloc would return
  output logic                   canAllocate,
  output logic                   clearSize,         // Zero size of nextArray
  output heapStoragePkg::arraySize busyArrays
);

  import heapStoragePkg::*;

  localparam logic [`HEAP_ADDRESS_BITS:0] ArrayCount = `HEAP_ARRAYS;

  logic [`HEAP_ADDRESS_BITS:0] highWater;           // Arrays ever handed out
  logic [`HEAP_ADDRESS_BITS:0] stackCount;          // Entries on freed stack
  logic [`HEAP_ARRAYS-1:0]     allocated;           // One flag per array
  arrayNum                     freedStack [`HEAP_ARRAYS];

  //----------------------------------------------------------------------
  // Lookups
  //----------------------------------------------------------------------
  assign arrayValid  = {1'b0, queryArray} < highWater;
  assign arrayFreed  = !allocated[queryArray];
  assign canAllocate = (stackCount != '0) || (highWater < ArrayCount);
  assign nextArray   = (stackCount != '0) ? freedStack[arrayNum'(stackCount - 1'b1)]
                                          : arrayNum'(highWater);   // Reuse first
  assign clearSize   = allocate;
  assign busyArrays  = arraySize'(highWater - stackCount);

  //----------------------------------------------------------------------
  // Updates
  //----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      highWater  <= '0;
      stackCount <= '0;
      allocated  <= '0;
    end else if (allocate) begin
      if (stackCount != '0) stackCount <= stackCount - 1'b1;    // Pop reused array
      else                  highWater  <= highWater + 1'b1;     // Fresh array
      allocated[nextArray] <= 1'b1;
    end else if (releaseArray) begin
      stackCount <= stackCount + 1'b1;
      allocated[queryArray] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray) freedStack[arrayNum'(stackCount)] <= queryArray;
  end

  // Double frees are caught upstream, so the stack can never overflow
  assert property (@(posedge clock) disable iff (!reset)
    releaseArray |-> stackCount < ArrayCount);

endmodule

`default_nettype wire

// File: design/heapArrayStore.sv
// Array element store
// Holds every array's elements and current size, applies writes, pushes,
// pops and in-place arithmetic, and counts elements against the request data

`default_nettype none

`include "heap_macros.svh"

module heapArrayStore (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          storeOp,       // Apply storeAction this edge
  input  heapOpsPkg::heapAction        storeAction,
  input  heapStoragePkg::arrayNum      array,
  input  heapStoragePkg::elementIndex  index,
  input  heapStoragePkg::elementData   data,
  input  wire                          clearSize,     // New array from allocator
  input  heapStoragePkg::arrayNum      newArray,
  output heapStoragePkg::arraySize     size,
  output heapStoragePkg::elementData   element,       // Value this action reports
  output heapStoragePkg::arraySize     lessCount,
  output heapStoragePkg::arraySize     greaterCount
);

  import heapStoragePkg::*;
  import heapOpsPkg::*;

  elementData memory [`HEAP_ARRAYS][`HEAP_LENGTH];    // Fixed block per array
  arraySize   sizes  [`HEAP_ARRAYS];
  elementData current;                                // Element at index
  elementData lastElement;                            // Element at size - 1
  elementData updated;                                // Arithmetic result

  //----------------------------------------------------------------------
  // Lookups
  //----------------------------------------------------------------------
  assign size        = sizes[array];
  assign current     = memory[array][index];
  assign lastElement = memory[array][elementIndex'(size - 1'b1)];

  always_comb begin
    case (storeAction)
      Add:      updated = current + data;
      Subtract: updated = current - data;
      And:      updated = current & data;
      Or:       updated = current | data;
      Xor:      updated = current ^ data;
      default:  updated = current;
    endcase
  end

  always_comb begin
    case (storeAction)
      Pop:                          element = lastElement;
      Add, Subtract, And, Or, Xor:  element = updated;     // New value
      default:                      element = current;
    endcase
  end

  // Scan only the live part of the array
  always_comb begin
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      if (arraySize'(i) < size) begin
        if (memory[array][i] < data) lessCount    = lessCount + 1'b1;
        if (memory[array][i] > data) greaterCount = greaterCount + 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // Element memory
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (storeOp) begin
      case (storeAction)
        Write:                        memory[array][index] <= data;
        Push:                         memory[array][elementIndex'(size)] <= data;
        Add, Subtract, And, Or, Xor:  memory[array][index] <= updated;
        default: ;                                          // Pop leaves data
      endcase
    end
  end

  // Sizes
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) sizes[a] <= '0;
    end else if (clearSize) begin
      sizes[newArray] <= '0;                                // Fresh array is empty
    end else if (storeOp) begin
      case (storeAction)
        Write: if (arraySize'(index) >= size) sizes[array] <= arraySize'(index) + 1'b1;
        Push:  sizes[array] <= size + 1'b1;
        Pop:   sizes[array] <= size - 1'b1;
        default: ;
      endcase
    end
  end

  // Full check lives in the command unit
  assert property (@(posedge clock) disable iff (!reset)
    size <= arraySize'(`HEAP_LENGTH));

endmodule

`default_nettype wire

// File: design/heapCommand.sv
// Heap command unit
// Checks each request, raises one enable for the allocator or the store,
// and registers done and the result one cycle after start

`default_nettype none

`include "heap_macros.svh"

module heapCommand (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        start,
  input  heapOpsPkg::heapRequest     request,
  input  wire                        arrayValid,
  input  wire                        arrayFreed,
  input  heapStoragePkg::arrayNum    nextArray,
  input  wire                        canAllocate,
  input  heapStoragePkg::arraySize   size,
  input  heapStoragePkg::elementData element,
  input  heapStoragePkg::arraySize   lessCount,
  input  heapStoragePkg::arraySize   greaterCount,
  output logic                       done,
  output heapOpsPkg::heapResult      result,
  output logic                       allocate,
  output logic                       releaseArray,
  output logic                       storeOp,
  output heapOpsPkg::heapAction      storeAction
);

  import heapStoragePkg::*;
  import heapOpsPkg::*;

  heapError   error;
  elementData outData;                               // Result data before register
  logic       inBounds;

  assign storeAction = request.action;               // Store decodes lookups too
  assign inBounds    = arraySize'(request.index) < size;

  //----------------------------------------------------------------------
  // Checks and enables
  //----------------------------------------------------------------------
  always_comb begin
    error        = none;
    outData      = '0;
    allocate     = 1'b0;
    releaseArray = 1'b0;
    storeOp      = 1'b0;
    if (request.action != Alloc && !arrayValid) error = notAllocated;
    else if (request.action != Alloc && arrayFreed) error = freed;
    else begin
      case (request.action)
        Alloc: begin
          if (canAllocate) begin
            allocate = start;
            outData  = elementData'(nextArray);
          end else error = outOfMemory;
        end
        Free:    releaseArray = start;
        Write: begin
          storeOp = start;
          outData = request.data;
        end
        Read:    if (inBounds) outData = element; else error = outOfBounds;
        Size:    outData = elementData'(size);
        Push:    if (size == arraySize'(`HEAP_LENGTH)) error = full; else storeOp = start;
        Pop: begin
          if (size == '0) error = empty;
          else begin
            storeOp = start;
            outData = element;                       // Last element
          end
        end
        Less:    outData = elementData'(lessCount);
        Greater: outData = elementData'(greaterCount);
        Add, Subtract, And, Or, Xor: begin
          if (inBounds) begin
            storeOp = start;
            outData = element;                       // Already the new value
          end else error = outOfBounds;
        end
        default: ;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Result register
  //----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= start;
      if (start) result <= '{data: outData, error: error};
    end
  end

  assert property (@(posedge clock) disable iff (!reset) done |-> $past(start));

  assert property (@(posedge clock) disable iff (!reset)
    $onehot0({allocate, releaseArray, storeOp}));

endmodule

`default_nettype wire

// File: design/heapTop.sv
// Array heap top level
// Command unit in front of the allocator and the element store

`default_nettype none

module heapTop (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      start,             // One request per strobe
  input  heapOpsPkg::heapRequest   request,
  output logic                     done,
  output heapOpsPkg::heapResult    result,
  output heapStoragePkg::arraySize busyArrays
);

  import heapStoragePkg::*;
  import heapOpsPkg::*;

  logic       arrayValid, arrayFreed, canAllocate, clearSize;
  logic       allocate, releaseArray, storeOp;
  arrayNum    nextArray;
  arraySize   size, lessCount, greaterCount;
  elementData element;
  heapAction  storeAction;

  heapCommand command (
    .clock, .reset, .start, .request,
    .arrayValid, .arrayFreed, .nextArray, .canAllocate,
    .size, .element, .lessCount, .greaterCount,
    .done, .result, .allocate, .releaseArray, .storeOp, .storeAction
  );

  heapAllocator allocator (
    .clock, .reset,
    .queryArray (request.array),
    .allocate, .releaseArray,
    .arrayValid, .arrayFreed, .nextArray, .canAllocate, .clearSize, .busyArrays
  );

  heapArrayStore store (
    .clock, .reset, .storeOp, .storeAction,
    .array (request.array), .index (request.index), .data (request.data),
    .clearSize,
    .newArray (nextArray),                            // Allocator's pick
    .size, .element, .lessCount, .greaterCount
  );

endmodule

`default_nettype wire

// File: test/heapTest.sv
// Array heap testbench
// Applies a table of requests to the heap top level and checks each result

`default_nettype none

`include "heap_macros.svh"

module heapTest;

  timeunit 1ns;
  timeprecision 1ps;

  import heapStoragePkg::*;
  import heapOpsPkg::*;

  localparam int DoneTimeout = 10;                   // Cycles to wait for done

  typedef struct packed {
    logic        start;
    heapAction   action;
    arrayNum     array;
    elementIndex index;
    elementData  data;
    elementData  expData;
    logic        checkIt;                            // Data is defined for this action
    heapError    expError;
    arraySize    expBusy;                            // busyArrays after the request
  } testRow;

  logic       clock;
  logic       reset;
  logic       start;
  heapRequest request;
  logic       done;
  heapResult  result;
  arraySize   busyArrays;

  testRow rows [$];
  integer seed = 32'h4133_5ee6;
  int     dataErrors, codeErrors, busyErrors, otherErrors;

  heapTop dut (.clock, .reset, .start, .request, .done, .result, .busyArrays);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;                      // 40 ns period
  end

  //----------------------------------------------------------------------
  // Checks
  //----------------------------------------------------------------------
  task automatic checkData(input string name, input elementData got, input elementData want);
    if (got !== want) begin
      $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, want);
      dataErrors++;
    end
  endtask

  task automatic checkError(input string name, input heapError got, input heapError want);
    if (got !== want) begin
      $display("[FAIL] %0d ns %s: got %s (%0d), expected %s", $time, name,
               got.name(), got, want.name());
      codeErrors++;
    end
  endtask

  task automatic checkBusy(input string name, input arraySize got, input arraySize want);
    if (got !== want) begin
      $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, want);
      busyErrors++;
    end
  endtask

  // Bounded wait, sampled away from the clock edge
  task automatic waitForDone(output bit seen, output int waited);
    seen   = 1'b0;
    waited = 0;
    for (int t = 0; t < DoneTimeout && !seen; t++) begin
      @(negedge clock);
      waited++;
      if (done) seen = 1'b1;
    end
  endtask

  //----------------------------------------------------------------------
  // Stimulus table
  //----------------------------------------------------------------------
  task automatic addRow(input heapAction act, input arrayNum arr, input elementIndex idx,
                        input elementData value, input logic checkIt, input elementData expData,
                        input heapError expError, input arraySize expBusy);
    rows.push_back('{start: 1'b1, action: act, array: arr, index: idx, data: value,
                     expData: expData, checkIt: checkIt, expError: expError,
                     expBusy: expBusy});
  endtask

  task automatic addIdle(input arraySize expBusy);
    rows.push_back('{start: 1'b0, action: Read, array: '0, index: '0, data: '0,
                     expData: '0, checkIt: 1'b0, expError: none, expBusy: expBusy});
  endtask

  task automatic buildTable();
    elementData value;
    elementData operand;
    heapAction  mathOps [5];
    mathOps = '{Add, Subtract, And, Or, Xor};
    // Fresh arrays in order, then freed ones in reverse
    addRow(Alloc, 0, 0, 0, 1'b1, 0, none, 1);
    addRow(Alloc, 0, 0, 0, 1'b1, 1, none, 2);
    addRow(Alloc, 0, 0, 0, 1'b1, 2, none, 3);
    addRow(Free, 1, 0, 0, 1'b0, 0, none, 2);
    addRow(Free, 2, 0, 0, 1'b0, 0, none, 1);
    addRow(Alloc, 0, 0, 0, 1'b1, 2, none, 2);
    addRow(Alloc, 0, 0, 0, 1'b1, 1, none, 3);
    addRow(Read, 5, 0, 0, 1'b0, 0, notAllocated, 3);   // Above high water
    // Write, size, read back, bounds
    addRow(Write, 0, 0, 10, 1'b1, 10, none, 3);
    addRow(Write, 0, 1, 20, 1'b1, 20, none, 3);
    addRow(Write, 0, 2, 30, 1'b1, 30, none, 3);
    addRow(Size, 0, 0, 0, 1'b1, 3, none, 3);
    addRow(Read, 0, 0, 0, 1'b1, 10, none, 3);
    addRow(Read, 0, 1, 0, 1'b1, 20, none, 3);
    addRow(Read, 0, 2, 0, 1'b1, 30, none, 3);
    addRow(Read, 0, 3, 0, 1'b0, 0, outOfBounds, 3);
    addRow(Less, 0, 0, 20, 1'b1, 1, none, 3);
    addRow(Greater, 0, 0, 5, 1'b1, 3, none, 3);
    // In-place arithmetic on element 1 with random operands
    value = elementData'($random(seed));
    addRow(Write, 0, 1, value, 1'b1, value, none, 3);
    foreach (mathOps[k]) begin
      operand = elementData'($random(seed));
      case (mathOps[k])
        Add:      value = value + operand;
        Subtract: value = value - operand;
        And:      value = value & operand;
        Or:       value = value | operand;
        default:  value = value ^ operand;
      endcase
      addRow(mathOps[k], 0, 1, operand, 1'b1, value, none, 3);
    end
    addRow(Read, 0, 1, 0, 1'b1, value, none, 3);
    addRow(Add, 0, 3, 1, 1'b0, 0, outOfBounds, 3);
    // Stack behavior on array 1
    addRow(Pop, 1, 0, 0, 1'b0, 0, empty, 3);
    for (int k = 0; k < `HEAP_LENGTH; k++)
      addRow(Push, 1, 0, elementData'(100 + k), 1'b0, 0, none, 3);
    addRow(Push, 1, 0, 999, 1'b0, 0, full, 3);
    addRow(Size, 1, 0, 0, 1'b1, `HEAP_LENGTH, none, 3);
    for (int k = `HEAP_LENGTH - 1; k >= 0; k--)
      addRow(Pop, 1, 0, 0, 1'b1, elementData'(100 + k), none, 3);
    addRow(Pop, 1, 0, 0, 1'b0, 0, empty, 3);
    // Freed array access and double free
    addRow(Write, 2, 4, 55, 1'b1, 55, none, 3);
    addRow(Size, 2, 0, 0, 1'b1, 5, none, 3);
    addRow(Free, 2, 0, 0, 1'b0, 0, none, 2);
    addRow(Read, 2, 0, 0, 1'b0, 0, freed, 2);
    addRow(Free, 2, 0, 0, 1'b0, 0, freed, 2);
    addIdle(2);
    // Reuse gives a cleared array, then fill the heap
    addRow(Alloc, 0, 0, 0, 1'b1, 2, none, 3);
    addRow(Size, 2, 0, 0, 1'b1, 0, none, 3);
    for (int a = 3; a < `HEAP_ARRAYS; a++)
      addRow(Alloc, 0, 0, 0, 1'b1, elementData'(a), none, arraySize'(a + 1));
    addRow(Alloc, 0, 0, 0, 1'b0, 0, outOfMemory, `HEAP_ARRAYS);
    addRow(Free, 7, 0, 0, 1'b0, 0, none, `HEAP_ARRAYS - 1);
    addRow(Alloc, 0, 0, 0, 1'b1, 7, none, `HEAP_ARRAYS);
    addRow(Read, 7, 0, 0, 1'b0, 0, outOfBounds, `HEAP_ARRAYS);
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin
    bit seen;
    int waited;
    reset   <= 1'b0;
    start   <= 1'b0;
    request <= '0;
    buildTable();
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    if (done) begin
      $display("done is high right after reset");
      otherErrors++;
    end
    checkData("result.data", result.data, '0);
    checkError("result.error", result.error, none);
    checkBusy("busyArrays", busyArrays, '0);

    foreach (rows[n]) begin
      @(posedge clock);
      start   <= rows[n].start;
      request <= '{action: rows[n].action, array: rows[n].array,
                   index: rows[n].index, data: rows[n].data};
      @(posedge clock);
      start <= 1'b0;
      if (rows[n].start) begin
        waitForDone(seen, waited);
        if (!seen) begin
          $display("Row %0d got no done pulse within %0d cycles", n, DoneTimeout);
          otherErrors++;
        end else begin
          if (waited != 1) begin
            $display("Row %0d saw done %0d cycles after start instead of one", n, waited);
            otherErrors++;
          end
          if (rows[n].checkIt) checkData("result.data", result.data, rows[n].expData);
          checkError("result.error", result.error, rows[n].expError);
          checkBusy("busyArrays", busyArrays, rows[n].expBusy);
        end
      end else begin
        @(negedge clock);
        if (done) begin
          $display("Row %0d saw done without a request", n);   // Idle cycle
          otherErrors++;
        end
      end
    end

    $display("Errors: data %0d, error code %0d, busy count %0d, other %0d",
             dataErrors, codeErrors, busyErrors, otherErrors);
    if (dataErrors + codeErrors + busyErrors + otherErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/heapStoragePkg.sv
design/heapOpsPkg.sv
design/heapAllocator.sv
design/heapArrayStore.sv
design/heapCommand.sv
design/heapTop.sv
test/heapTest.sv

// File: Makefile
# Verilator build and run for the array heap testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = heapTest
FILELIST  = compile.f
BUILD     = obj_dir
PASS_TEXT = TEST RESULT: PASS
SOURCES   = $(wildcard design/*.sv include/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)
